// ==== hdl/phy_ctrl_pkg.sv ====
// PIPE PHY control constants, counter widths and state encodings
package phy_ctrl_pkg;

   // ========================================================================
   // Timer lengths, scaled down for simulation
   // ========================================================================
   // Detect enable time before the charge timer starts
   localparam int DET_EN_CLKS     = 16;
   // Counter value that ends the charge timer
   localparam int DET_CT_CLKS     = 19;
   // Glitch mask after far-end receiver detection
   localparam int EI_MASK_CLKS    = 8;
   // One quiet period (scaled millisecond)
   localparam int PERIOD_CLKS     = 8;
   // Quiet periods before RxValid is passed
   localparam int RX_WAIT_PERIODS = 4;

   // Counter widths
   typedef logic [7:0]  det_cnt_t;
   typedef logic [6:0]  ei_cnt_t;
   typedef logic [16:0] period_cnt_t;
   typedef logic [2:0]  period_num_t;

   // PIPE PowerDown encoding
   typedef enum logic [1:0] {
      P0  = 2'b00,
      P0S = 2'b01,
      P1  = 2'b10,
      P2  = 2'b11
   } power_state_t;

   // Receiver detect sequence
   typedef enum logic [1:0] {DET_IDLE, DET_EN, DET_CT, DET_DONE} det_state_t;

endpackage

// ==== hdl/phy_ctrl_if.sv ====
`timescale 1ns/1ps
// Shared lock, detect and idle-mask status between the PHY control blocks
interface phy_ctrl_if;

   // Synchronized PLL lock
   logic pll_locked;
   // One-cycle pulse at end of receiver detection
   logic detsm_done;
   // Electrical idle with post-detect glitch masked
   logic rx_ei_masked;
   // Glitch mask window active
   logic start_mask;

   // Detect FSM side
   modport detect (output detsm_done);

   // PhyStatus side
   modport status (output pll_locked, input detsm_done);

   // Idle glitch mask side
   modport mask (input pll_locked, output rx_ei_masked, output start_mask);

   // RxValid gate side
   modport gate (input rx_ei_masked, input start_mask);

endinterface

// ==== hdl/rx_detect_fsm.sv ====
`timescale 1ns/1ps
// Receiver detect sequencer for PCS detect enable and charge timer strobes
module rx_detect_fsm import phy_ctrl_pkg::*; (
   input  logic         PCLK,
   input  logic         pcie_ip_rstn,
   input  power_state_t power_down,
   input  logic         tx_detect_rx_loopback,
   input  logic         tx_elec_idle,
   input  logic         pcs_done,
   output logic         pcie_det_en,
   output logic         pcie_ct,
   phy_ctrl_if.detect   ctl
);

   det_state_t state;
   det_cnt_t   det_cnt;
   logic       det_req;
   logic       req_s1;
   logic       req_s2;
   logic       req_s2_d;
   logic       req_rise;
   logic       en_done;
   logic       ct_done;
   logic       done_s1;
   logic       done_s2;
   logic       done_s3;
   logic       done_rise;

   // Request only counts in P1 with the transmitter idle
   assign det_req   = (power_down == P1) & tx_detect_rx_loopback & tx_elec_idle;
   assign req_rise  = req_s2 & ~req_s2_d;
   assign done_rise = done_s2 & ~done_s3;

   // ========================================================================
   // Request edge and PCS done synchronizer
   // ========================================================================
   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         req_s1   <= 1'b0;
         req_s2   <= 1'b0;
         req_s2_d <= 1'b0;
         done_s1  <= 1'b0;
         done_s2  <= 1'b0;
         done_s3  <= 1'b0;
      end else begin
         req_s1   <= det_req;
         req_s2   <= req_s1;
         req_s2_d <= req_s2;
         // pcs_done comes from the PCS clock domain
         done_s1  <= pcs_done;
         done_s2  <= done_s1;
         done_s3  <= done_s2;
      end
   end

   // Timer runs only while enabling and charging
   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         det_cnt <= '0;
         en_done <= 1'b0;
         ct_done <= 1'b0;
      end else begin
         if (state == DET_EN || state == DET_CT)
            det_cnt <= det_cnt + 1'b1;
         else
            det_cnt <= '0;
         en_done <= (det_cnt == det_cnt_t'(DET_EN_CLKS));
         ct_done <= (det_cnt == det_cnt_t'(DET_CT_CLKS));
      end
   end

   // ========================================================================
   // Detect state machine
   // ========================================================================
   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         state          <= DET_IDLE;
         pcie_det_en    <= 1'b0;
         pcie_ct        <= 1'b0;
         ctl.detsm_done <= 1'b0;
      end else begin
         case (state)
            DET_IDLE: begin
               ctl.detsm_done <= 1'b0;
               // New detection only starts from idle
               if (req_rise) begin
                  state       <= DET_EN;
                  pcie_det_en <= 1'b1;
               end
            end
            DET_EN: begin
               if (en_done) begin
                  state   <= DET_CT;
                  pcie_ct <= 1'b1;
               end
            end
            DET_CT: begin
               if (ct_done) begin
                  state   <= DET_DONE;
                  pcie_ct <= 1'b0;
               end
            end
            DET_DONE: begin
               // Latency set by the PCS
               if (done_rise) begin
                  state          <= DET_IDLE;
                  pcie_det_en    <= 1'b0;
                  ctl.detsm_done <= 1'b1;
               end
            end
            default: state <= DET_IDLE;
         endcase
      end
   end

   // Charge strobe only inside its state and within detect enable
   a_ct_in_state: assert property (@(posedge PCLK) disable iff (!pcie_ip_rstn)
      pcie_ct |-> state == DET_CT);
   a_ct_with_en: assert property (@(posedge PCLK) disable iff (!pcie_ip_rstn)
      pcie_ct |-> pcie_det_en);

endmodule

// ==== hdl/phy_status_gen.sv ====
`timescale 1ns/1ps
// PhyStatus pulse generation on power state changes and detect completion
module phy_status_gen import phy_ctrl_pkg::*; (
   input  logic         PCLK,
   input  logic         pcie_ip_rstn,
   input  power_state_t power_down,
   input  logic         pll_lol,
   output logic         phy_status,
   phy_ctrl_if.status   ctl
);

   logic         lol_s1;
   logic         lol_s2;
   power_state_t pd_q;
   logic         trans_hit;
   logic         status_cause;

   assign ctl.pll_locked = ~lol_s2;

   // PIPE transitions that complete with a PhyStatus pulse
   assign trans_hit = (pd_q == P0  && power_down == P2)  ||
                      (pd_q == P2  && power_down == P1)  ||
                      (pd_q == P0  && power_down == P0S) ||
                      (pd_q == P0S && power_down == P0)  ||
                      (pd_q == P0  && power_down == P1)  ||
                      (pd_q == P1  && power_down == P0);

   assign status_cause = trans_hit | ctl.detsm_done;

   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         lol_s1     <= 1'b1;
         lol_s2     <= 1'b1;
         pd_q       <= P0;
         phy_status <= 1'b1;
      end else begin
         // Loss of lock is asynchronous to PCLK
         lol_s1 <= pll_lol;
         lol_s2 <= lol_s1;
         pd_q   <= power_down;
         // Held high until the PLL locks
         if (!lol_s2)
            phy_status <= status_cause;
      end
   end

   // Back-to-back pulses after lock need a cause for each cycle
   a_status_cause: assert property (@(posedge PCLK) disable iff (!pcie_ip_rstn)
      ($past(ctl.pll_locked) && $past(ctl.pll_locked, 2) &&
       phy_status && $past(phy_status))
      |-> ($past(status_cause) && $past(status_cause, 2)));

endmodule

// ==== hdl/ei_glitch_mask.sv ====
`timescale 1ns/1ps
// Electrical idle synchronizer with post-detect glitch mask
module ei_glitch_mask import phy_ctrl_pkg::*; (
   input  logic     PCLK,
   input  logic     pcie_ip_rstn,
   input  logic     rx_elec_idle_in,
   output logic     rx_elec_idle,
   phy_ctrl_if.mask ctl
);

   logic    ei_s1;
   logic    ei_s2;
   logic    check;
   logic    check_nxt;
   logic    mask_nxt;
   ei_cnt_t ei_cnt;

   assign ctl.rx_ei_masked = rx_elec_idle;

   // Arm on idle, mask the first drop after it
   always_comb begin
      check_nxt = check;
      mask_nxt  = ctl.start_mask;
      if (ctl.pll_locked) begin
         if (ei_s2)
            check_nxt = 1'b1;
         if (ctl.start_mask && ei_cnt == ei_cnt_t'(EI_MASK_CLKS - 1)) begin
            mask_nxt  = 1'b0;
            check_nxt = 1'b0;
         end else if (check && !ei_s2) begin
            mask_nxt = 1'b1;
         end
      end else begin
         // Nothing to mask without a locked PLL
         check_nxt = 1'b0;
         mask_nxt  = 1'b0;
      end
   end

   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         ei_s1          <= 1'b1;
         ei_s2          <= 1'b1;
         check          <= 1'b0;
         ctl.start_mask <= 1'b0;
         ei_cnt         <= '0;
         rx_elec_idle   <= 1'b1;
      end else begin
         ei_s1          <= rx_elec_idle_in;
         ei_s2          <= ei_s1;
         check          <= check_nxt;
         ctl.start_mask <= mask_nxt;
         if (ctl.start_mask)
            ei_cnt <= ei_cnt + 1'b1;
         else
            ei_cnt <= '0;
         // Forced idle while the mask window is open
         rx_elec_idle <= ei_s2 | mask_nxt;
      end
   end

   a_mask_len: assert property (@(posedge PCLK) disable iff (!pcie_ip_rstn)
      $rose(ctl.start_mask) |-> ##EI_MASK_CLKS !ctl.start_mask);

endmodule

// ==== hdl/rx_valid_gate.sv ====
`timescale 1ns/1ps
// Quiet-period timer that holds RxValid low until the lane has settled
module rx_valid_gate import phy_ctrl_pkg::*; (
   input  logic     PCLK,
   input  logic     pcie_ip_rstn,
   input  logic     pcs_con,
   input  logic     rx_lol,
   input  logic     rx_valid_in,
   output logic     rx_valid,
   phy_ctrl_if.gate ctl
);

   logic        ei_det;
   logic        ei_low;
   logic        ei_low_pulse;
   logic        all_ei_high;
   logic        lol_s1;
   logic        lol_s2;
   logic        lol_d;
   logic        lol_rise;
   logic        restart;
   logic        det_done;
   logic        start_count;
   logic        start_count_d;
   logic        count_en;
   logic        period_end;
   period_cnt_t period_cnt;
   period_num_t period_num;
   logic        pcs_wait_done;

   // Lane connected and out of electrical idle
   assign ei_det     = ~ctl.rx_ei_masked & pcs_con;
   assign period_end = (period_cnt == period_cnt_t'(PERIOD_CLKS - 1));

   // ========================================================================
   // Restart conditions and timer arming
   // ========================================================================
   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         lol_s1        <= 1'b1;
         lol_s2        <= 1'b1;
         lol_d         <= 1'b1;
         ei_low        <= 1'b0;
         ei_low_pulse  <= 1'b0;
         all_ei_high   <= 1'b0;
         lol_rise      <= 1'b0;
         restart       <= 1'b0;
         det_done      <= 1'b0;
         start_count   <= 1'b0;
         start_count_d <= 1'b0;
      end else begin
         lol_s1 <= rx_lol;
         lol_s2 <= lol_s1;
         lol_d  <= lol_s2;
         // New drop out of idle while counting
         ei_low       <= count_en & ei_det;
         ei_low_pulse <= ~ei_low & count_en & ei_det;
         // Lane went back to idle while counting
         all_ei_high  <= count_en & ~ei_low;
         // CDR lost lock with the lane active
         lol_rise     <= ei_low & lol_s2 & ~lol_d;
         restart      <= ei_low_pulse | all_ei_high | lol_rise;
         // Armed while idle and the timer is stopped
         if (det_done) begin
            if (start_count)
               det_done <= 1'b0;
         end else if (ctl.rx_ei_masked && !count_en) begin
            det_done <= 1'b1;
         end
         start_count   <= det_done & ei_det;
         start_count_d <= start_count;
      end
   end

   // ========================================================================
   // Quiet-period timer and RxValid qualification
   // ========================================================================
   always_ff @(posedge PCLK or negedge pcie_ip_rstn) begin
      if (!pcie_ip_rstn) begin
         count_en      <= 1'b0;
         period_cnt    <= '0;
         period_num    <= '0;
         pcs_wait_done <= 1'b0;
         rx_valid      <= 1'b0;
      end else begin
         if (start_count && !start_count_d)
            count_en <= 1'b1;
         else if (period_num == period_num_t'(RX_WAIT_PERIODS))
            count_en <= 1'b0;
         // Every restart begins the wait from zero
         if (!count_en || restart) begin
            period_cnt <= '0;
            period_num <= '0;
         end else if (period_end) begin
            period_cnt <= '0;
            period_num <= period_num + 1'b1;
         end else begin
            period_cnt <= period_cnt + 1'b1;
         end
         if (period_num == period_num_t'(RX_WAIT_PERIODS))
            pcs_wait_done <= 1'b1;
         else if (ctl.rx_ei_masked)
            pcs_wait_done <= 1'b0;
         rx_valid <= pcs_wait_done & ~ctl.rx_ei_masked & ~ctl.start_mask & rx_valid_in;
      end
   end

   a_valid_not_idle: assert property (@(posedge PCLK) disable iff (!pcie_ip_rstn)
      rx_valid |-> !$past(ctl.rx_ei_masked));

endmodule

// ==== hdl/pcie_phy_ctrl.sv ====
`timescale 1ns/1ps
// Single-lane PCIe PIPE PHY control top with detect, status, idle and RxValid logic
module pcie_phy_ctrl import phy_ctrl_pkg::*; (
   input  logic         PCLK,
   input  logic         pcie_ip_rstn,
   input  power_state_t power_down,
   input  logic         tx_detect_rx_loopback,
   input  logic         tx_elec_idle,
   input  logic         pll_lol,
   input  logic         pcs_done,
   input  logic         pcs_con,
   input  logic         rx_elec_idle_in,
   input  logic         rx_lol,
   input  logic         rx_valid_in,
   output logic         pcie_det_en,
   output logic         pcie_ct,
   output logic         phy_status,
   output logic         rx_elec_idle,
   output logic         rx_valid
);

   // Status shared between the four blocks
   phy_ctrl_if ctl_if ();

   rx_detect_fsm rx_detect_fsm_i (
      .PCLK                  (PCLK),
      .pcie_ip_rstn          (pcie_ip_rstn),
      .power_down            (power_down),
      .tx_detect_rx_loopback (tx_detect_rx_loopback),
      .tx_elec_idle          (tx_elec_idle),
      .pcs_done              (pcs_done),
      .pcie_det_en           (pcie_det_en),
      .pcie_ct               (pcie_ct),
      .ctl                   (ctl_if.detect)
   );

   phy_status_gen phy_status_gen_i (
      .PCLK         (PCLK),
      .pcie_ip_rstn (pcie_ip_rstn),
      .power_down   (power_down),
      .pll_lol      (pll_lol),
      .phy_status   (phy_status),
      .ctl          (ctl_if.status)
   );

   ei_glitch_mask ei_glitch_mask_i (
      .PCLK            (PCLK),
      .pcie_ip_rstn    (pcie_ip_rstn),
      .rx_elec_idle_in (rx_elec_idle_in),
      .rx_elec_idle    (rx_elec_idle),
      .ctl             (ctl_if.mask)
   );

   rx_valid_gate rx_valid_gate_i (
      .PCLK         (PCLK),
      .pcie_ip_rstn (pcie_ip_rstn),
      .pcs_con      (pcs_con),
      .rx_lol       (rx_lol),
      .rx_valid_in  (rx_valid_in),
      .rx_valid     (rx_valid),
      .ctl          (ctl_if.gate)
   );

endmodule

// ==== tb/tb_pcie_phy_ctrl.sv ====
// Random-stimulus testbench for the single-lane PCIe PIPE PHY control top level
`timescale 1ns/1ps
module tb_pcie_phy_ctrl import phy_ctrl_pkg::*; ();

   // ========================================================================
   // Run lengths and timeout
   // ========================================================================
   localparam int N_DET        = 6;
   localparam int N_PWR        = 200;
   // Shortest quiet stretch before RxValid may pass
   localparam int QUIET_CLKS   = RX_WAIT_PERIODS * PERIOD_CLKS;
   // Extra cycles allowed for synchronizers and restart pipeline
   localparam int FOLLOW_SLACK = 10;
   localparam int SCRIPT_CLKS  = 5 + 40 + 10 + N_PWR + 4 + N_DET * 60 + 120;
   localparam int LIMIT_CLKS   = 20 * SCRIPT_CLKS;

   logic         PCLK;
   logic         pcie_ip_rstn;
   power_state_t power_down;
   logic         tx_detect_rx_loopback;
   logic         tx_elec_idle;
   logic         pll_lol;
   logic         pcs_done;
   logic         pcs_con;
   logic         rx_elec_idle_in;
   logic         rx_lol;
   logic         rx_valid_in;
   logic         pcie_det_en;
   logic         pcie_ct;
   logic         phy_status;
   logic         rx_elec_idle;
   logic         rx_valid;

   logic [15:0]  lfsr;
   int           value_errs = 0;
   int           proto_errs = 0;
   int           cycle = 0;
   int           ticks = 0;

   pcie_phy_ctrl dut_i (.*);

   initial begin
      PCLK = 1'b0;
      forever #4 PCLK = ~PCLK;
   end

   // Watchdog on raw clock edges
   always @(posedge PCLK) begin
      ticks <= ticks + 1;
      if (ticks >= LIMIT_CLKS) begin
         $display("ERROR: run stopped after %0d cycles without finishing", ticks);
         $display("value errors %0d, protocol errors %0d", value_errs, proto_errs + 1);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // ========================================================================
   // Helpers
   // ========================================================================
   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      if (got !== expected) begin
         value_errs++;
         $display("FAILED %s: got 0x%0h expected 0x%0h at cycle %0d",
                  name, got, expected, cycle);
      end
   endtask

   task automatic report(input string msg);
      proto_errs++;
      $display("ERROR at cycle %0d: %s", cycle, msg);
   endtask

   // Outputs are sampled and inputs driven on the falling edge
   task automatic step();
      @(negedge PCLK);
      cycle++;
   endtask

   // PIPE power transitions that complete with PhyStatus
   function automatic logic pulse_expected(input power_state_t from, input power_state_t to);
      case ({from, to})
         {P0, P2}, {P2, P1}, {P0, P0S}, {P0S, P0}, {P0, P1}, {P1, P0}: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // ========================================================================
   // Receiver detection with a small PCS model
   // ========================================================================
   task automatic run_detect();
      int n;
      int width;
      int delay;
      int pulses;
      tx_detect_rx_loopback = 1'b1;
      tx_elec_idle          = 1'b1;
      n = 0;
      while (!pcie_det_en && n < 8) begin
         step();
         n++;
      end
      if (!pcie_det_en) begin
         report("pcie_det_en did not rise after the detect request");
         tx_detect_rx_loopback = 1'b0;
         return;
      end
      // Charge strobe 18 cycles after detect enable
      n = 0;
      while (!pcie_ct && n < 40) begin
         step();
         n++;
      end
      compare("pcie_ct_delay", n, 18);
      width = 0;
      while (pcie_ct && width < 10) begin
         if (!pcie_det_en)
            report("pcie_ct high without pcie_det_en");
         step();
         width++;
      end
      compare("pcie_ct_width", width, DET_CT_CLKS - DET_EN_CLKS);
      // PCS answers 1 to 15 cycles after the charge strobe
      delay = 1 + int'(rand_bits(4) % 15);
      for (int i = 0; i < delay; i++) begin
         step();
         if (!pcie_det_en)
            report("pcie_det_en fell before pcs_done");
      end
      pcs_done = 1'b1;
      n = 0;
      while (pcie_det_en && n < 10) begin
         step();
         n++;
      end
      if (pcie_det_en)
         report("pcie_det_en did not fall after pcs_done");
      // PCS clears done once detect enable drops
      pcs_done              = 1'b0;
      tx_detect_rx_loopback = 1'b0;
      pulses = 0;
      for (int i = 0; i < 5; i++) begin
         if (phy_status)
            pulses++;
         step();
      end
      compare("phy_status_pulses", pulses, 1);
      repeat (3) step();
   endtask

   // ========================================================================
   // Random power states against the transition list
   // ========================================================================
   task automatic run_power(input int count);
      logic [1:0]   pick;
      power_state_t next_pd;
      logic         expect_pulse;
      expect_pulse = 1'b0;
      for (int i = 0; i < count; i++) begin
         step();
         compare("phy_status", 32'(phy_status), 32'(expect_pulse));
         pick    = 2'(rand_bits(2));
         next_pd = power_state_t'(pick);
         // Hold the state about half the time
         if (rand_bits(1) != 0)
            next_pd = power_down;
         expect_pulse = pulse_expected(power_down, next_pd);
         power_down   = next_pd;
      end
      // Last change of the sequence
      step();
      compare("phy_status", 32'(phy_status), 32'(expect_pulse));
   endtask

   // ========================================================================
   // Idle glitch mask and RxValid quiet wait
   // ========================================================================
   task automatic run_rx_path();
      int   n;
      int   age;
      int   drop_cyc;
      int   quiet_start;
      int   lol_cyc;
      logic seen_low;
      drop_cyc        = cycle;
      quiet_start     = cycle;
      lol_cyc         = -10;
      seen_low        = 1'b0;
      rx_elec_idle_in = 1'b0;
      while (!seen_low || cycle - quiet_start < QUIET_CLKS + 30) begin
         step();
         age = cycle - quiet_start;
         if (!seen_low) begin
            compare("rx_valid", 32'(rx_valid), 32'd0);
            if (!rx_elec_idle) begin
               seen_low = 1'b1;
               n        = cycle - drop_cyc;
               // Two sync stages and the output register around the mask
               if (n < EI_MASK_CLKS + 2 || n > EI_MASK_CLKS + 4)
                  report("rx_elec_idle dropped outside the glitch mask window");
               quiet_start = cycle;
               lol_cyc     = cycle + 1 + int'(rand_bits(5) % 20);
            end else if (cycle - drop_cyc > 40) begin
               report("rx_elec_idle never dropped after rx_elec_idle_in fell");
               break;
            end
         end else if (age < QUIET_CLKS) begin
            compare("rx_valid", 32'(rx_valid), 32'd0);
         end else if (age >= QUIET_CLKS + FOLLOW_SLACK) begin
            // rx_valid_in still holds the value driven one cycle earlier
            compare("rx_valid", 32'(rx_valid), 32'(rx_valid_in));
         end else if (rx_valid && !rx_valid_in) begin
            report("rx_valid high while rx_valid_in was low");
         end
         // CDR loss of lock restarts the quiet wait
         if (cycle == lol_cyc) begin
            rx_lol      = 1'b1;
            quiet_start = cycle;
         end else if (cycle == lol_cyc + 4) begin
            rx_lol = 1'b0;
         end
         rx_valid_in = (rand_bits(1) != 0);
      end
   endtask

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial begin
      logic [1:0] pick;
      lfsr                  = 16'd29380;
      pcie_ip_rstn          = 1'b0;
      power_down            = P0;
      tx_detect_rx_loopback = 1'b0;
      tx_elec_idle          = 1'b0;
      pll_lol               = 1'b1;
      pcs_done              = 1'b0;
      pcs_con               = 1'b1;
      rx_elec_idle_in       = 1'b1;
      rx_lol                = 1'b0;
      rx_valid_in           = 1'b0;
      repeat (5) @(posedge PCLK);
      step();
      pcie_ip_rstn = 1'b1;
      step();

      // Reset values
      compare("pcie_det_en", 32'(pcie_det_en), 32'd0);
      compare("pcie_ct", 32'(pcie_ct), 32'd0);
      compare("rx_valid", 32'(rx_valid), 32'd0);
      compare("phy_status", 32'(phy_status), 32'd1);
      compare("rx_elec_idle", 32'(rx_elec_idle), 32'd1);

      // PhyStatus held high while the PLL is unlocked
      for (int i = 0; i < 40; i++) begin
         step();
         compare("phy_status", 32'(phy_status), 32'd1);
         pick       = 2'(rand_bits(2));
         power_down = power_state_t'(pick);
      end
      power_down = P0;
      repeat (4) step();
      pll_lol = 1'b0;
      repeat (6) step();
      compare("phy_status", 32'(phy_status), 32'd0);

      run_power(N_PWR);

      // Detection runs from P1
      power_down = P1;
      repeat (4) step();
      for (int i = 0; i < N_DET; i++)
         run_detect();

      run_rx_path();

      $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== pcie_phy_ctrl.f ====
hdl/phy_ctrl_pkg.sv
hdl/phy_ctrl_if.sv
hdl/rx_detect_fsm.sv
hdl/phy_status_gen.sv
hdl/ei_glitch_mask.sv
hdl/rx_valid_gate.sv
hdl/pcie_phy_ctrl.sv
tb/tb_pcie_phy_ctrl.sv

// ==== Makefile ====
TOP = tb_pcie_phy_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module pcie_phy_ctrl hdl/phy_ctrl_pkg.sv \
		hdl/phy_ctrl_if.sv hdl/rx_detect_fsm.sv hdl/phy_status_gen.sv \
		hdl/ei_glitch_mask.sv hdl/rx_valid_gate.sv hdl/pcie_phy_ctrl.sv
	verilator --lint-only --timing --top-module $(TOP) -f pcie_phy_ctrl.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f pcie_phy_ctrl.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
